// File: Makefile
TOP = tb_ppu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: fir_to_posit.sv
`timescale 1ns/1ps

module fir_to_posit
  import ppu_pkg::*;
(
  input  ops_result_t ops_result_i,
  output posit_t      posit_o
);

  logic signed [TE_BITS-1:0] te_clamped;
  logic [K_BITS-1:0]         k;
  logic [ES-1:0]             exp_bits;
  logic [K_BITS-1:0]         shamt;
  logic [SHIFT_SIZE-1:0]     field;
  logic [SHIFT_SIZE-1:0]     field_shifted;
  logic [N-2:0]              body;
  logic                      guard;
  logic                      round_bit;
  logic                      sticky;
  logic                      round_up;
  logic [N-2:0]              body_rounded;
  posit_t                    p_mag;

  // clamping alone lands out-of-range values on maxpos or minpos
  always_comb begin
    if ($signed(ops_result_i.te) > TE_MAX) begin
      te_clamped = TE_MAX;
    end else if ($signed(ops_result_i.te) < -TE_MAX) begin
      te_clamped = -TE_MAX;
    end else begin
      te_clamped = $signed(ops_result_i.te);
    end
  end

  assign k = te_clamped[ES +: K_BITS];
  assign exp_bits = te_clamped[ES-1:0];
  assign shamt = k[K_BITS-1] ? ~k : k; // -k-1 for a negative regime

  // "10" or "01" seeds the regime, the arithmetic shift extends the run
  assign field = {~k[K_BITS-1], k[K_BITS-1], exp_bits,
                  ops_result_i.frac_full[FRAC_FULL_SIZE-2:0],
                  {(SHIFT_SIZE - ES - FRAC_FULL_SIZE - 1){1'b0}}};
  assign field_shifted = $signed(field) >>> shamt;

  assign body = field_shifted[SHIFT_SIZE-1 -: N-1];
  assign guard = field_shifted[SHIFT_SIZE-N];
  assign round_bit = field_shifted[SHIFT_SIZE-N-1];
  assign sticky = (|field_shifted[SHIFT_SIZE-N-2:0]) | ops_result_i.sticky;
  assign round_up = guard & (body[0] | round_bit | sticky);  // ties go to the even pattern

  // an all-ones body only comes with the largest regime, whose guard bit is zero
  assign body_rounded = body + round_up;
  assign p_mag = {1'b0, body_rounded};

  always_comb begin
    if (ops_result_i.frac_full == '0) begin
      posit_o = '0;
    end else if (ops_result_i.sign) begin
      posit_o = -p_mag;
    end else begin
      posit_o = p_mag;
    end
  end

endmodule

// File: input_conditioning.sv
`timescale 1ns/1ps

module input_conditioning
  import ppu_pkg::*;
(
  input  operation_e op_i,
  input  posit_t     p1_i,
  input  posit_t     p2_i,
  output posit_t     p1_o,
  output posit_t     p2_o,
  output special_t   special_o
);

  logic p1_zero;
  logic p2_zero;

  assign p1_zero = (p1_i == '0);
  assign p2_zero = (p2_i == '0);

  assign p1_o = p1_i;
  assign p2_o = (op_i == OP_SUB) ? -p2_i : p2_i; // subtraction becomes addition of the negation

  always_comb begin
    special_o = '0;
    if ((p1_i == NAR) || (p2_i == NAR)) begin
      special_o.is_special = 1'b1;
      special_o.value = NAR;
    end else if (op_i == OP_MUL) begin
      if (p1_zero || p2_zero) begin
        special_o.is_special = 1'b1; // value stays zero
      end
    end else if (p1_zero) begin
      special_o.is_special = 1'b1;
      special_o.value = p2_o;
    end else if (p2_zero) begin
      special_o.is_special = 1'b1;
      special_o.value = p1_i;
    end
  end

endmodule

// File: ops.sv
`timescale 1ns/1ps

module ops
  import ppu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  operation_e  op_i,
  input  fir_t        fir1_i,
  input  fir_t        fir2_i,
  output ops_result_t ops_result_o
);

  logic [FRAC_FULL_SIZE-1:0]     prod;
  ops_result_t                   mul_res;
  ops_result_t                   add_res;
  fir_t                          fir_hi;
  fir_t                          fir_lo;
  logic [TE_BITS-1:0]            te_diff;
  logic [TE_BITS-1:0]            shamt;
  logic [SUM_SIZE-1:0]           hi_field;
  logic [SUM_SIZE-1:0]           lo_field;
  logic [2*SUM_SIZE-1:0]         lo_ext;
  logic                          align_sticky;
  logic [SUM_SIZE-1:0]           sum;
  logic [$clog2(SUM_SIZE)-1:0]   lz;
  logic                          lz_done;

  always_comb begin
    prod = fir1_i.mant * fir2_i.mant;
    mul_res.sign = fir1_i.sign ^ fir2_i.sign;
    mul_res.sticky = 1'b0; // the product is exact
    if (prod[FRAC_FULL_SIZE-1]) begin
      mul_res.te = fir1_i.te + fir2_i.te + 1'b1;
      mul_res.frac_full = prod;
    end else begin
      mul_res.te = fir1_i.te + fir2_i.te;
      mul_res.frac_full = prod << 1;
    end
    if (fir1_i.zero || fir2_i.zero) begin
      mul_res.frac_full = '0;
    end
  end

  // order the operands by magnitude so the difference never goes negative
  always_comb begin
    if (($signed(fir1_i.te) > $signed(fir2_i.te)) ||
        ((fir1_i.te == fir2_i.te) && (fir1_i.mant >= fir2_i.mant))) begin
      fir_hi = fir1_i;
      fir_lo = fir2_i;
    end else begin
      fir_hi = fir2_i;
      fir_lo = fir1_i;
    end
  end

  always_comb begin
    te_diff = fir_hi.te - fir_lo.te;
    shamt = (te_diff > SUM_SIZE) ? TE_BITS'(SUM_SIZE) : te_diff;
    hi_field = {1'b0, fir_hi.mant, {MANT_SIZE{1'b0}}};
    lo_ext = {1'b0, fir_lo.mant, {MANT_SIZE{1'b0}}, {SUM_SIZE{1'b0}}} >> shamt;
    lo_field = lo_ext[2*SUM_SIZE-1 -: SUM_SIZE];
    align_sticky = |lo_ext[SUM_SIZE-1:0];
    if (fir_hi.sign == fir_lo.sign) begin
      sum = hi_field + lo_field;
    end else begin
      sum = hi_field - lo_field - align_sticky; // sticky acts as a borrow below the field
    end
  end

  always_comb begin
    lz = '0;
    lz_done = 1'b0;
    for (int i = FRAC_FULL_SIZE - 1; i >= 0; i--) begin
      if (!lz_done && !sum[i]) begin
        lz = lz + 1'b1;
      end else begin
        lz_done = 1'b1;
      end
    end
  end

  always_comb begin
    add_res.sign = fir_hi.sign;
    if (sum[SUM_SIZE-1]) begin
      add_res.te = fir_hi.te + 1'b1;
      add_res.frac_full = sum[SUM_SIZE-1:1];
      add_res.sticky = align_sticky | sum[0];
    end else begin
      // an exact zero sum leaves frac_full at zero
      add_res.te = fir_hi.te - lz;
      add_res.frac_full = sum[FRAC_FULL_SIZE-1:0] << lz;
      add_res.sticky = align_sticky;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ops_result_o <= '0;
    end else begin
      ops_result_o <= (op_i == OP_MUL) ? mul_res : add_res;
    end
  end

endmodule

// File: posit_to_fir.sv
`timescale 1ns/1ps

module posit_to_fir
  import ppu_pkg::*;
(
  input  posit_t p_cond_i,
  output fir_t   fir_o
);

  posit_t            p_abs;
  logic [N-2:0]      body;
  logic [N-2:0]      body_shifted;
  logic [K_BITS-1:0] run;
  logic              run_done;
  logic [K_BITS-1:0] k;
  logic [ES-1:0]     exp_bits;

  assign p_abs = p_cond_i[N-1] ? -p_cond_i : p_cond_i;
  assign body = p_abs[N-2:0];

  // length of the regime run, counted from the bit after the sign
  always_comb begin
    run = '0;
    run_done = 1'b0;
    for (int i = N - 2; i >= 0; i--) begin
      if (!run_done && (body[i] == body[N-2])) begin
        run = run + 1'b1;
      end else begin
        run_done = 1'b1;
      end
    end
  end

  assign k = body[N-2] ? (run - 1'b1) : -run;

  // drop the regime and its terminating bit
  assign body_shifted = body << (run + 1'b1);
  assign exp_bits = body_shifted[N-2 -: ES];

  always_comb begin
    fir_o.sign = p_cond_i[N-1];
    fir_o.te = {{(TE_BITS - K_BITS - ES){k[K_BITS-1]}}, k, exp_bits}; // k * 2^ES + exp
    fir_o.mant = {1'b1, body_shifted[N-2-ES -: MANT_SIZE-1]};
    fir_o.zero = (p_cond_i == '0);
  end

endmodule

// File: ppu.sv
`timescale 1ns/1ps

module ppu
  import ppu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       valid_i,
  input  operation_e op_i,
  input  posit_t     p1_i,
  input  posit_t     p2_i,
  output logic       valid_o,
  output operation_e op_o,
  output posit_t     pout_o
);

  logic [PIPE_DEPTH-1:0] valid_sr;
  operation_e            op_q;
  posit_t                p1_q;
  posit_t                p2_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_sr <= '0;
      op_q <= OP_ADD;
      p1_q <= '0;   // zero operands keep the output at zero after reset
      p2_q <= '0;
    end else begin
      valid_sr <= {valid_sr[PIPE_DEPTH-2:0], valid_i};
      op_q <= op_i;
      p1_q <= p1_i;
      p2_q <= p2_i;
    end
  end

  ppu_core_ops i_ppu_core_ops (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .op_i   (op_q),
    .p1_i   (p1_q),
    .p2_i   (p2_q),
    .op_o   (op_o),
    .pout_o (pout_o)
  );

  assign valid_o = valid_sr[PIPE_DEPTH-1];

endmodule

// File: ppu_core_ops.sv
`timescale 1ns/1ps

module ppu_core_ops
  import ppu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  operation_e op_i,
  input  posit_t     p1_i,
  input  posit_t     p2_i,
  output operation_e op_o,
  output posit_t     pout_o
);

  posit_t      p1_cond;
  posit_t      p2_cond;
  special_t    special_st0;
  special_t    special_st1;
  special_t    special_st2;
  fir_t        fir1;
  fir_t        fir2;
  ops_result_t ops_st1;
  ops_result_t ops_st2;
  operation_e  op_st1;
  posit_t      pout_fir;

  input_conditioning i_input_conditioning (
    .op_i      (op_i),
    .p1_i      (p1_i),
    .p2_i      (p2_i),
    .p1_o      (p1_cond),
    .p2_o      (p2_cond),
    .special_o (special_st0)
  );

  posit_to_fir i_posit_to_fir1 (
    .p_cond_i (p1_cond),
    .fir_o    (fir1)
  );

  posit_to_fir i_posit_to_fir2 (
    .p_cond_i (p2_cond),
    .fir_o    (fir2)
  );

  ops i_ops (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .op_i         (op_i),
    .fir1_i       (fir1),
    .fir2_i       (fir2),
    .ops_result_o (ops_st1)
  );

  fir_to_posit i_fir_to_posit (
    .ops_result_i (ops_st2),
    .posit_o      (pout_fir)
  );

  // special results and the operation follow the two arithmetic stages
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ops_st2 <= '0;
      special_st1 <= '0;
      special_st2 <= '0;
      op_st1 <= OP_ADD;
      op_o <= OP_ADD;
    end else begin
      ops_st2 <= ops_st1;
      special_st1 <= special_st0;
      special_st2 <= special_st1;
      op_st1 <= op_i;
      op_o <= op_st1;
    end
  end

  assign pout_o = special_st2.is_special ? special_st2.value : pout_fir;

endmodule

// File: ppu_pkg.sv
package ppu_pkg;

  localparam int N = 16;
  localparam int ES = 1;
  localparam int K_BITS = 5;                       // signed regime value
  localparam int TE_BITS = 7;                      // room for the sum of two exponents
  localparam int MANT_SIZE = 13;                   // hidden bit plus twelve fraction bits
  localparam int FRAC_FULL_SIZE = 2 * MANT_SIZE;
  localparam int SUM_SIZE = FRAC_FULL_SIZE + 1;    // aligned sum with a carry bit
  localparam int SHIFT_SIZE = 48;                  // encoder field, regime never pushes bits out
  localparam int PIPE_DEPTH = 3;

  localparam logic [N-1:0] NAR = 16'h8000;
  localparam logic [N-1:0] MAXPOS = 16'h7fff;
  localparam logic [N-1:0] MINPOS = 16'h0001;

  // largest total exponent, reached by maxpos and minpos
  localparam logic signed [TE_BITS-1:0] TE_MAX = 7'sd28;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2
  } operation_e;

  typedef logic [N-1:0] posit_t;

  typedef struct packed {
    logic                 sign;
    logic [TE_BITS-1:0]   te;
    logic [MANT_SIZE-1:0] mant;    // hidden bit at the top
    logic                 zero;
  } fir_t;

  // frac_full carries its leading one at the top bit unless the result is zero
  typedef struct packed {
    logic                      sign;
    logic [TE_BITS-1:0]        te;
    logic [FRAC_FULL_SIZE-1:0] frac_full;
    logic                      sticky;
  } ops_result_t;

  typedef struct packed {
    logic   is_special;
    posit_t value;
  } special_t;

endpackage

// File: ppu_stimulus.txt
# name op p1 p2 expected, all hex; op 0 is add, 1 is sub, 2 is mul
nar_add       0 8000 4000 8000
nar_sub       1 4000 8000 8000
nar_mul       2 8000 0000 8000
zero_mul      2 0000 5800 0000
add_zero      0 5800 0000 5800
zero_sub      1 0000 4800 b800
add_1_1       0 4000 4000 5000
add_neg       0 4000 b000 c000
sub_3_1       1 5800 4000 5000
sub_half      1 3000 4800 c000
sub_cancel    1 5800 5800 0000
add_tie_odd   0 4001 00c0 4002
mul_2_3       2 5000 5800 6400
mul_tie_down  2 4002 4400 4402
mul_tie_up    2 4001 4800 4802
mul_sticky_up 2 4003 42ab 42af
mul_round_dn  2 4003 42aa 42ad
mul_maxpos    2 7fff 7fff 7fff
mul_minpos    2 0001 0001 0001

// File: sim.f
ppu_pkg.sv
input_conditioning.sv
posit_to_fir.sv
ops.sv
fir_to_posit.sv
ppu_core_ops.sv
ppu.sv
tb_ppu.sv

// File: tb_ppu.sv
`timescale 1ns/1ps

module tb_ppu
  import ppu_pkg::*;
();

  logic       clk;
  logic       rst;
  logic       valid_in;
  operation_e op_in;
  posit_t     p1_in;
  posit_t     p2_in;
  logic       valid_out;
  operation_e op_out;
  posit_t     pout_out;

  // expected results in the order the vectors went in
  string      name_q[$];
  operation_e op_exp_q[$];
  posit_t     pout_exp_q[$];
  int         entry_q[$];

  int pass_count = 0;
  int fail_count = 0;
  int vector_count = 0;
  int pulse_count = 0;
  int cycle_count = 0;
  int fd;

  ppu i_dut (
    .clk_i   (clk),
    .rst_i   (rst),
    .valid_i (valid_in),
    .op_i    (op_in),
    .p1_i    (p1_in),
    .p2_i    (p2_in),
    .valid_o (valid_out),
    .op_o    (op_out),
    .pout_o  (pout_out)
  );

  always #20 clk = ~clk;

  always @(posedge clk) cycle_count++;

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      fail_count++;
    end else begin
      $display("ok %s %0h", name, actual);
      pass_count++;
    end
  endtask

  // one vector per cycle, inputs change 2 ns after the edge
  task automatic stream_vectors();
    string      line;
    string      name;
    int         fields;
    logic [1:0] op_val;
    posit_t     p1_val;
    posit_t     p2_val;
    posit_t     exp_val;
    while (!$feof(fd)) begin
      line = "";
      fields = 0;
      if ($fgets(line, fd) != 0 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %h %h %h %h", name, op_val, p1_val, p2_val, exp_val);
      end
      if (fields == 5) begin
        @(posedge clk);
        #2;
        valid_in = 1'b1;
        op_in = operation_e'(op_val);
        p1_in = p1_val;
        p2_in = p2_val;
        name_q.push_back(name);
        op_exp_q.push_back(operation_e'(op_val));
        pout_exp_q.push_back(exp_val);
        entry_q.push_back(cycle_count);
        vector_count++;
      end else if (fields > 0) begin
        $display("stimulus line could not be read: %s", line);
        fail_count++;
      end
    end
    @(posedge clk);
    #2;
    valid_in = 1'b0;
  endtask

  task automatic drain();
    int wait_cycles;
    wait_cycles = 0;
    while (name_q.size() != 0 && wait_cycles < 20) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (name_q.size() != 0) begin
      $display("timeout, %0d results never left the DUT", name_q.size());
      fail_count++;
    end
  endtask

  // outputs settle after the rising edge, so they are sampled on the falling one
  always @(negedge clk) begin
    if (!rst && valid_out) begin
      pulse_count++;
      if (name_q.size() == 0) begin
        $display("valid_o went high with no vector outstanding");
        fail_count++;
      end else begin
        compare(name_q[0], pout_exp_q[0], pout_out);
        compare({name_q[0], "_op"}, op_exp_q[0], op_out);
        compare({name_q[0], "_latency"}, 3, cycle_count - entry_q[0]);
        void'(name_q.pop_front());
        void'(op_exp_q.pop_front());
        void'(pout_exp_q.pop_front());
        void'(entry_q.pop_front());
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    valid_in = 1'b0;
    op_in = OP_ADD;
    p1_in = '0;
    p2_in = '0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int i = 1; i <= 3; i++) begin
      @(negedge clk);
      compare($sformatf("reset_idle_%0d", i), {15'b0, valid_out, pout_out}, 32'h0);
    end
    fd = $fopen("ppu_stimulus.txt", "r");
    if (fd == 0) begin
      $display("the stimulus file ppu_stimulus.txt could not be opened");
      fail_count++;
    end else begin
      stream_vectors();
      $fclose(fd);
      drain();
      repeat (4) @(posedge clk); // no stray pulses after the last result
      compare("pulse_count", vector_count, pulse_count);
    end
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
